// File: compile.f
+incdir+include
src/board_pkg.sv
src/input_debouncer.sv
src/rate_tick_generator.sv
src/step_counter.sv
src/hex_display.sv
src/board_top.sv
tests/tb_board_top.sv

// File: include/board_params.svh
`ifndef BOARD_PARAMS_SVH
`define BOARD_PARAMS_SVH

`define BOARD_NUM_SW          10
`define BOARD_NUM_KEY         4
`define BOARD_NUM_DIGITS      6
`define BOARD_COUNT_W         24

// a new level passes after 2**4 stable cycles.
`define BOARD_DEBOUNCE_DEPTH  4
`define BOARD_DIV_POW         6

`endif

// File: src/board_pkg.sv
`include "board_params.svh"

package board_pkg;

    // debounced switches that steer the tick rate and the counter.
    typedef struct packed
    {
        logic sel_lo;
        logic sel_mid;
        logic run;
    } controls_t;

    // counter value, seen by the display as separate hex digits.
    typedef union packed
    {
        logic [`BOARD_COUNT_W-1:0]             count;
        logic [`BOARD_NUM_DIGITS-1:0][3:0]     digits;  // digit 0 is the low nibble.
    } display_word_u;

    // active low, bit 6 is segment g and bit 0 is segment a.
    typedef logic [6:0] segments_t;

endpackage

// File: src/board_top.sv
`timescale 1ns/1ps
`include "board_params.svh"

module board_top
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic [`BOARD_NUM_SW-1:0]  sw,
    input  logic [`BOARD_NUM_KEY-1:0] key,   // active low, keys 1 to 3 unused.
    output logic [`BOARD_NUM_SW-1:0]  ledr,
    output board_pkg::segments_t      hex0,
    output board_pkg::segments_t      hex1,
    output board_pkg::segments_t      hex2,
    output board_pkg::segments_t      hex3,
    output board_pkg::segments_t      hex4,
    output board_pkg::segments_t      hex5
);

    logic [`BOARD_NUM_SW-1:0]  sw_db;
    logic                      clear;
    logic                      tick;
    board_pkg::controls_t      ctrl;
    board_pkg::display_word_u  value;

    for (genvar i = 0; i < `BOARD_NUM_SW; i++)
    begin : gen_sw_db
        input_debouncer u_sw_db
        (
            .clk   ( clk      ),
            .rst   ( rst      ),
            .raw   ( sw[i]    ),
            .clean ( sw_db[i] )
        );
    end

    // key pressed pulls the pin low, clear is high while held.
    input_debouncer u_key_db
    (
        .clk   ( clk     ),
        .rst   ( rst     ),
        .raw   ( ~key[0] ),
        .clean ( clear   )
    );

    assign ctrl.sel_lo  = sw_db[0];
    assign ctrl.sel_mid = sw_db[1];
    assign ctrl.run     = sw_db[2];

    assign ledr = sw_db;

    rate_tick_generator u_tick_gen
    (
        .clk  ( clk  ),
        .rst  ( rst  ),
        .ctrl ( ctrl ),
        .tick ( tick )
    );

    step_counter u_step_counter
    (
        .clk   ( clk   ),
        .rst   ( rst   ),
        .tick  ( tick  ),
        .ctrl  ( ctrl  ),
        .clear ( clear ),
        .value ( value )
    );

    hex_display u_hex_display
    (
        .value ( value ),
        .hex0  ( hex0  ),
        .hex1  ( hex1  ),
        .hex2  ( hex2  ),
        .hex3  ( hex3  ),
        .hex4  ( hex4  ),
        .hex5  ( hex5  )
    );

endmodule

// File: src/hex_display.sv
`timescale 1ns/1ps
`include "board_params.svh"

module hex_display
(
    input  board_pkg::display_word_u value,
    output board_pkg::segments_t     hex0,
    output board_pkg::segments_t     hex1,
    output board_pkg::segments_t     hex2,
    output board_pkg::segments_t     hex3,
    output board_pkg::segments_t     hex4,
    output board_pkg::segments_t     hex5
);

    board_pkg::segments_t segs [`BOARD_NUM_DIGITS];

    //   --a--
    //  f     b
    //   --g--
    //  e     c
    //   --d--
    function automatic board_pkg::segments_t decode(input logic [3:0] nibble);
        board_pkg::segments_t pattern;
        case (nibble)
            4'h0: pattern = 7'b1000000;
            4'h1: pattern = 7'b1111001;
            4'h2: pattern = 7'b0100100;
            4'h3: pattern = 7'b0110000;
            4'h4: pattern = 7'b0011001;
            4'h5: pattern = 7'b0010010;
            4'h6: pattern = 7'b0000010;
            4'h7: pattern = 7'b1111000;
            4'h8: pattern = 7'b0000000;
            4'h9: pattern = 7'b0011000;
            4'ha: pattern = 7'b0001000;
            4'hb: pattern = 7'b0000011;
            4'hc: pattern = 7'b1000110;
            4'hd: pattern = 7'b0100001;
            4'he: pattern = 7'b0000110;
            default: pattern = 7'b0001110;  // f.
        endcase
        return pattern;
    endfunction

    always_comb
    begin
        for (int i = 0; i < `BOARD_NUM_DIGITS; i++)
            segs[i] = decode(value.digits[i]);
    end

    assign hex0 = segs[0];
    assign hex1 = segs[1];
    assign hex2 = segs[2];
    assign hex3 = segs[3];
    assign hex4 = segs[4];
    assign hex5 = segs[5];

endmodule

// File: src/input_debouncer.sv
`timescale 1ns/1ps
`include "board_params.svh"

module input_debouncer
#(
    parameter int DEPTH = `BOARD_DEBOUNCE_DEPTH
)
(
    input  logic clk,
    input  logic rst,
    input  logic raw,
    output logic clean
);

    logic [2:0]     sync;
    logic           level;
    logic [DEPTH:0] cnt;    // top bit set once the new level has held 2**DEPTH cycles.

    assign level = sync[2];

    always_ff @(posedge clk)
    begin
        if (rst)
            sync <= '0;
        else
            sync <= {sync[1:0], raw};
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            cnt   <= '0;
            clean <= 1'b0;
        end
        else if (cnt[DEPTH])
        begin
            cnt   <= '0;
            clean <= level;  // a level that just reverted leaves clean as it was.
        end
        else if (level != clean)
            cnt <= cnt + 1'b1;
        else
            cnt <= '0;
    end

endmodule

// File: src/rate_tick_generator.sv
`timescale 1ns/1ps
`include "board_params.svh"

module rate_tick_generator
#(
    parameter int DIV_POW = `BOARD_DIV_POW
)
(
    input  logic                 clk,
    input  logic                 rst,
    input  board_pkg::controls_t ctrl,
    output logic                 tick
);

    logic [DIV_POW-1:0] div;
    logic               wrap_slow;
    logic               wrap_mid;
    logic               tick_next;

    // the divider wraps to zero on the edge after it is all ones.
    assign wrap_slow = &div;
    assign wrap_mid  = &div[DIV_POW-5:0];

    always_comb
    begin
        if (ctrl.sel_lo)
            tick_next = wrap_slow;
        else if (ctrl.sel_mid)
            tick_next = wrap_mid;
        else
            tick_next = 1'b1;  // fast rate.
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            div  <= '0;
            tick <= 1'b0;
        end
        else
        begin
            div  <= div + 1'b1;
            tick <= tick_next;
        end
    end

endmodule

// File: src/step_counter.sv
`timescale 1ns/1ps
`include "board_params.svh"

module step_counter
(
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     tick,
    input  board_pkg::controls_t     ctrl,
    input  logic                     clear,
    output board_pkg::display_word_u value
);

    logic [`BOARD_COUNT_W-1:0] count_q;
    logic [`BOARD_COUNT_W-1:0] count_next;
    logic                      step;

    assign step = tick & ctrl.run;

    // clear wins over a step in the same cycle.
    always_comb
    begin
        count_next = count_q;
        if (clear)
            count_next = '0;
        else if (step)
            count_next = count_q + 1'b1;  // wraps modulo 2**24.
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            count_q <= '0;
        else
            count_q <= count_next;
    end

    assign value.count = count_q;

endmodule

// File: tests/board_tests.mem
// columns: test id (2 hex), sw (3 hex), key (1 hex, active low), cycles to hold (4 hex).
// a row with 0000 cycles is a glitch whose length the testbench draws from its LFSR.
01000f0008
012a8f001e
023a8f0000
022a8f0018
022a0f0000
022a8f0018
022a8e0000
022a8f0018
032acf0028
032acf0258
042adf012c
052aef0078
042aff0096
052aef0064
062aee0028
062acf0050
072a8f003c
072acf0000
072a8f001e
062a8e001e
062a8f0019
031acf0190
08000f0020

// File: tests/tb_board_top.sv
`timescale 1ns/1ps
`include "board_params.svh"

module tb_board_top;

    localparam int clk_period      = 100;
    localparam int reset_cycles    = 3;
    localparam int margin_cycles   = 200;
    localparam int num_rows        = 23;
    localparam int num_lines       = `BOARD_NUM_SW + 1;  // ten switches plus key 0.
    localparam int clear_line      = `BOARD_NUM_SW;
    localparam int debounce_cycles = 1 << `BOARD_DEBOUNCE_DEPTH;
    localparam int slow_period     = 1 << `BOARD_DIV_POW;
    localparam int mid_period      = 1 << (`BOARD_DIV_POW - 4);

    logic                      clk;
    logic                      rst;
    logic [`BOARD_NUM_SW-1:0]  sw;
    logic [`BOARD_NUM_KEY-1:0] key;
    logic [`BOARD_NUM_SW-1:0]  ledr;
    board_pkg::segments_t      hex0;
    board_pkg::segments_t      hex1;
    board_pkg::segments_t      hex2;
    board_pkg::segments_t      hex3;
    board_pkg::segments_t      hex4;
    board_pkg::segments_t      hex5;

    // id [39:32], sw [31:20], key [19:16], cycles [15:0].
    logic [39:0]               rows [num_rows];
    logic [31:0]               lfsr_state;
    int                        limit_cycles;
    bit                        rows_loaded;

    // reference model, one entry per debounced line.
    logic [num_lines-1:0]      model_sync1;
    logic [num_lines-1:0]      model_sync2;
    logic [num_lines-1:0]      model_sync3;
    logic [num_lines-1:0]      model_clean;
    int                        model_differ [num_lines];
    int                        model_edges;  // active edges since reset.
    logic                      model_tick;
    logic [`BOARD_COUNT_W-1:0] model_count;

    board_top u_board_top
    (
        .clk  ( clk  ),
        .rst  ( rst  ),
        .sw   ( sw   ),
        .key  ( key  ),
        .ledr ( ledr ),
        .hex0 ( hex0 ),
        .hex1 ( hex1 ),
        .hex2 ( hex2 ),
        .hex3 ( hex3 ),
        .hex4 ( hex4 ),
        .hex5 ( hex5 )
    );

    initial
        clk = 1'b0;

    always #(clk_period / 2) clk = ~clk;

    // active low, bit 6 is segment g.
    function automatic board_pkg::segments_t segments_for(input logic [3:0] nibble);
        case (nibble)
            4'h0: return 7'h40;
            4'h1: return 7'h79;
            4'h2: return 7'h24;
            4'h3: return 7'h30;
            4'h4: return 7'h19;
            4'h5: return 7'h12;
            4'h6: return 7'h02;
            4'h7: return 7'h78;
            4'h8: return 7'h00;
            4'h9: return 7'h18;
            4'ha: return 7'h08;
            4'hb: return 7'h03;
            4'hc: return 7'h46;
            4'hd: return 7'h21;
            4'he: return 7'h06;
            default: return 7'h0e;
        endcase
    endfunction

    function automatic string test_name(input logic [7:0] id);
        case (id)
            8'h01: return "switch_hold";
            8'h02: return "glitch_reject";
            8'h03: return "fast_count";
            8'h04: return "slow_rate";
            8'h05: return "mid_rate";
            8'h06: return "key_clear";
            8'h07: return "run_freeze";
            8'h08: return "switches_off";
            default: return "unknown";
        endcase
    endfunction

    // galois form, taps for x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        if (state[0])
            return (state >> 1) ^ 32'h80200003;
        else
            return state >> 1;
    endfunction

    // one bit per step, so the length stays below the debounce depth.
    function automatic int glitch_length();
        int len;
        len = 0;
        for (int b = 0; b < `BOARD_DEBOUNCE_DEPTH; b++)
        begin
            len        = (len << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_step(lfsr_state);
        end
        if (len == 0)
            len = 1;
        return len;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic value_mismatch(input string name, input string what,
                                  input logic [31:0] expected, input logic [31:0] actual);
        abort_run($sformatf("Fail %s: %s expected %0h actual %0h", name, what, expected, actual));
    endtask

    // one rising edge of the board, inputs as they stood before the edge.
    task automatic advance_model();
        logic [num_lines-1:0]      raw_now;
        logic [num_lines-1:0]      clean_next;
        logic                      tick_next;
        logic [`BOARD_COUNT_W-1:0] count_next;
        int                        div_after;
        raw_now    = {~key[0], sw};
        clean_next = model_clean;
        for (int i = 0; i < num_lines; i++)
        begin
            if (model_differ[i] == debounce_cycles)
            begin
                clean_next[i]   = model_sync3[i];  // saturated, take the synchronized level.
                model_differ[i] = 0;
            end
            else if (model_sync3[i] != model_clean[i])
                model_differ[i]++;
            else
                model_differ[i] = 0;
        end
        model_edges++;
        div_after = model_edges % slow_period;  // divider value once this edge is taken.
        if (model_clean[0])
            tick_next = (div_after == 0);
        else if (model_clean[1])
            tick_next = (div_after % mid_period == 0);
        else
            tick_next = 1'b1;
        if (model_clean[clear_line])
            count_next = '0;
        else if (model_tick && model_clean[2])
            count_next = model_count + 1'b1;
        else
            count_next = model_count;
        model_sync3 = model_sync2;
        model_sync2 = model_sync1;
        model_sync1 = raw_now;
        model_clean = clean_next;
        model_tick  = tick_next;
        model_count = count_next;
    endtask

    task automatic check_outputs(input string name);
        board_pkg::segments_t seen [`BOARD_NUM_DIGITS];
        board_pkg::segments_t expected;
        seen[0] = hex0;
        seen[1] = hex1;
        seen[2] = hex2;
        seen[3] = hex3;
        seen[4] = hex4;
        seen[5] = hex5;
        assert (ledr === model_clean[`BOARD_NUM_SW-1:0])
        else
            value_mismatch(name, "ledr", 32'(model_clean[`BOARD_NUM_SW-1:0]), 32'(ledr));
        for (int d = 0; d < `BOARD_NUM_DIGITS; d++)
        begin
            expected = segments_for(model_count[4*d +: 4]);
            assert (seen[d] === expected)
            else
                value_mismatch(name, $sformatf("hex%0d", d), 32'(expected), 32'(seen[d]));
        end
    endtask

    task automatic run_row(input logic [39:0] row);
        string name;
        int    length;
        name   = test_name(row[39:32]);
        length = int'(row[15:0]);
        if (length == 0)
            length = glitch_length();
        sw  = row[`BOARD_NUM_SW+19:20];
        key = row[19:16];
        repeat (length)
        begin
            @(posedge clk);
            advance_model();
            #1;
            check_outputs(name);
        end
    endtask

    initial
    begin
        wait (rows_loaded);
        #(limit_cycles * clk_period);
        abort_run($sformatf("timeout: the test rows did not finish within %0d clock cycles",
                            limit_cycles));
    end

    initial
    begin
        rst         = 1'b1;
        sw          = '0;
        key         = '1;  // keys idle high.
        lfsr_state  = 32'hfd28;
        model_sync1 = '0;
        model_sync2 = '0;
        model_sync3 = '0;
        model_clean = '0;
        model_edges = 0;
        model_tick  = 1'b0;
        model_count = '0;
        for (int i = 0; i < num_lines; i++)
            model_differ[i] = 0;

        $readmemh("tests/board_tests.mem", rows);
        assert (!$isunknown(rows[num_rows-1]))
        else
            abort_run("the data file tests/board_tests.mem could not be read in full");

        // a glitch row never runs longer than the debounce depth.
        limit_cycles = reset_cycles + margin_cycles;
        for (int r = 0; r < num_rows; r++)
            limit_cycles += (rows[r][15:0] == 0) ? debounce_cycles : int'(rows[r][15:0]);
        rows_loaded = 1'b1;

        repeat (reset_cycles) @(posedge clk);
        #1;
        rst = 1'b0;
        check_outputs("reset");

        for (int r = 0; r < num_rows; r++)
            run_row(rows[r]);

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule
